// File: common/fused_mult_config.svh
`ifndef FUSED_MULT_CONFIG_SVH
`define FUSED_MULT_CONFIG_SVH

// operand widths
`define FM_OPERAND_W     54
`define FM_SLICE_W       9

// slice product and final sum
`define FM_SLICE_PROD_W  18
`define FM_RESULT_W      45

// number of 9x9 slice multipliers
`define FM_NUM_SLICES    6

// mode codes
`define FM_MODE_27X18    2'd0
`define FM_MODE_SUM9     2'd1
`define FM_MODE_SUM4     2'd2
`define FM_MODE_SUM2     2'd3

`endif

// File: common/fused_mult_pkg.sv
`default_nettype none

`include "fused_mult_config.svh"

package fused_mult_pkg;

	// one full input operand
	typedef logic [`FM_OPERAND_W-1:0] operand_t;

	// operand bits seen by one slice multiplier
	typedef logic [`FM_SLICE_W-1:0] slice_t;

	// slice product, two's complement when the slice is signed
	typedef logic [`FM_SLICE_PROD_W-1:0] slice_prod_t;

	// reduced sum of all slices
	typedef logic [`FM_RESULT_W-1:0] result_t;

	// holds one of the FM_MODE codes
	typedef logic [1:0] mode_t;

endpackage

`default_nettype wire

// File: src/operand_distributor.sv
`default_nettype none

`include "fused_mult_config.svh"

module operand_distributor (
	input  fused_mult_pkg::operand_t a,
	input  fused_mult_pkg::operand_t b,
	input  logic                     a_sign,
	input  logic                     b_sign,
	input  fused_mult_pkg::mode_t    mode,
	output fused_mult_pkg::slice_t   a_slice      [`FM_NUM_SLICES],
	output fused_mult_pkg::slice_t   b_slice      [`FM_NUM_SLICES],
	output logic                     a_slice_sign [`FM_NUM_SLICES],
	output logic                     b_slice_sign [`FM_NUM_SLICES]
);

	// 27 bits of a in three parts, 18 bits of b in two
	localparam int A_PARTS = 3;
	localparam int B_PARTS = 2;

	logic wide_mode;

	assign wide_mode = (mode == `FM_MODE_27X18);

	always_comb begin
		for (int k = 0; k < `FM_NUM_SLICES; k++) begin
			if (wide_mode) begin
				// slice k pairs a-part k%3 with b-part k/3
				a_slice[k] = a[`FM_SLICE_W*(k % A_PARTS) +: `FM_SLICE_W];
				b_slice[k] = b[`FM_SLICE_W*(k / A_PARTS) +: `FM_SLICE_W];

				// lower parts are magnitude bits only
				a_slice_sign[k] = a_sign && ((k % A_PARTS) == (A_PARTS - 1));
				b_slice_sign[k] = b_sign && ((k / A_PARTS) == (B_PARTS - 1));
			end else begin
				// simd lanes, slice k owns bits 9k+8:9k of both operands
				a_slice[k] = a[`FM_SLICE_W*k +: `FM_SLICE_W];
				b_slice[k] = b[`FM_SLICE_W*k +: `FM_SLICE_W];

				a_slice_sign[k] = a_sign;
				b_slice_sign[k] = b_sign;
			end
		end
	end

endmodule

`default_nettype wire

// File: slice_mult/slice_mult.sv
`default_nettype none

`include "fused_mult_config.svh"

module slice_mult (
	input  logic                        clk,
	input  logic                        reset,
	input  fused_mult_pkg::slice_t      a_slice,
	input  fused_mult_pkg::slice_t      b_slice,
	input  logic                        a_sign,
	input  logic                        b_sign,
	input  fused_mult_pkg::mode_t       mode,
	output fused_mult_pkg::slice_prod_t product
);

	localparam int LANE4_W = 4;
	localparam int LANES4  = 2;
	localparam int LANE2_W = 2;
	localparam int LANES2  = 4;

	// full 9x9, one extra bit to carry the sign
	logic signed [`FM_SLICE_W:0]     a_full;
	logic signed [`FM_SLICE_W:0]     b_full;
	logic signed [2*`FM_SLICE_W+1:0] prod_full;

	logic signed [LANE4_W:0]     a_lane4    [LANES4];
	logic signed [LANE4_W:0]     b_lane4    [LANES4];
	logic signed [2*LANE4_W+1:0] prod_lane4 [LANES4];

	logic signed [LANE2_W:0]     a_lane2    [LANES2];
	logic signed [LANE2_W:0]     b_lane2    [LANES2];
	logic signed [2*LANE2_W+1:0] prod_lane2 [LANES2];

	logic signed [`FM_SLICE_PROD_W-1:0] sum4;
	logic signed [`FM_SLICE_PROD_W-1:0] sum2;
	fused_mult_pkg::slice_prod_t        product_next;

	assign a_full    = {a_sign & a_slice[`FM_SLICE_W-1], a_slice};
	assign b_full    = {b_sign & b_slice[`FM_SLICE_W-1], b_slice};
	assign prod_full = a_full * b_full;

	// two 4-bit lanes, bit 8 unused
	always_comb begin
		sum4 = '0;
		for (int l = 0; l < LANES4; l++) begin
			a_lane4[l] = {a_sign & a_slice[LANE4_W*l+LANE4_W-1], a_slice[LANE4_W*l +: LANE4_W]};
			b_lane4[l] = {b_sign & b_slice[LANE4_W*l+LANE4_W-1], b_slice[LANE4_W*l +: LANE4_W]};
			prod_lane4[l] = a_lane4[l] * b_lane4[l];
			sum4 = sum4 + prod_lane4[l];
		end
	end

	// four 2-bit lanes
	always_comb begin
		sum2 = '0;
		for (int l = 0; l < LANES2; l++) begin
			a_lane2[l] = {a_sign & a_slice[LANE2_W*l+LANE2_W-1], a_slice[LANE2_W*l +: LANE2_W]};
			b_lane2[l] = {b_sign & b_slice[LANE2_W*l+LANE2_W-1], b_slice[LANE2_W*l +: LANE2_W]};
			prod_lane2[l] = a_lane2[l] * b_lane2[l];
			sum2 = sum2 + prod_lane2[l];
		end
	end

	always_comb begin
		case (mode)
			`FM_MODE_SUM4: product_next = sum4;
			`FM_MODE_SUM2: product_next = sum2;
			// 27x18 and sum9 both use the whole slice
			default:       product_next = prod_full[`FM_SLICE_PROD_W-1:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			product <= '0;
		end else begin
			product <= product_next;
		end
	end

endmodule

`default_nettype wire

// File: src/product_reducer.sv
`default_nettype none

`include "fused_mult_config.svh"

module product_reducer (
	input  logic                        clk,
	input  logic                        reset,
	input  fused_mult_pkg::slice_prod_t product [`FM_NUM_SLICES],
	input  fused_mult_pkg::mode_t       mode,
	input  logic                        a_sign,
	input  logic                        b_sign,
	output fused_mult_pkg::result_t     result
);

	localparam int A_PARTS = 3;
	localparam int B_PARTS = 2;
	localparam int EXT_W   = `FM_RESULT_W - `FM_SLICE_PROD_W;

	fused_mult_pkg::mode_t   mode_q;
	logic                    a_sign_q;
	logic                    b_sign_q;
	logic                    wide_mode_q;
	logic                    slice_signed [`FM_NUM_SLICES];
	fused_mult_pkg::result_t term_ext     [`FM_NUM_SLICES];
	fused_mult_pkg::result_t term         [`FM_NUM_SLICES];
	fused_mult_pkg::result_t sum;

	// controls follow the products through the slice register
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q   <= `FM_MODE_27X18;
			a_sign_q <= 1'b0;
			b_sign_q <= 1'b0;
		end else begin
			mode_q   <= mode;
			a_sign_q <= a_sign;
			b_sign_q <= b_sign;
		end
	end

	assign wide_mode_q = (mode_q == `FM_MODE_27X18);

	// same sign rules as the distributor, one cycle later
	always_comb begin
		for (int k = 0; k < `FM_NUM_SLICES; k++) begin
			if (wide_mode_q) begin
				slice_signed[k] = (a_sign_q && ((k % A_PARTS) == (A_PARTS - 1)))
					|| (b_sign_q && ((k / A_PARTS) == (B_PARTS - 1)));
			end else begin
				slice_signed[k] = a_sign_q || b_sign_q;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < `FM_NUM_SLICES; k++) begin
			term_ext[k] = {{EXT_W{slice_signed[k] & product[k][`FM_SLICE_PROD_W-1]}},
				product[k]};
			// weight 2^(9*(i+j)) for the wide multiply
			if (wide_mode_q) begin
				term[k] = term_ext[k] << (`FM_SLICE_W * ((k % A_PARTS) + (k / A_PARTS)));
			end else begin
				term[k] = term_ext[k];
			end
		end
	end

	// adder tree, wraps modulo 2^45
	always_comb begin
		sum = '0;
		for (int k = 0; k < `FM_NUM_SLICES; k++) begin
			sum = sum + term[k];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else begin
			result <= sum;
		end
	end

endmodule

`default_nettype wire

// File: src/fused_mult_top.sv
`default_nettype none

`include "fused_mult_config.svh"

module fused_mult_top (
	input  logic                     clk,
	input  logic                     reset,
	input  fused_mult_pkg::operand_t a,
	input  fused_mult_pkg::operand_t b,
	input  logic                     a_sign,
	input  logic                     b_sign,
	input  fused_mult_pkg::mode_t    mode,
	output fused_mult_pkg::result_t  result
);

	fused_mult_pkg::slice_t      a_slice      [`FM_NUM_SLICES];
	fused_mult_pkg::slice_t      b_slice      [`FM_NUM_SLICES];
	logic                        a_slice_sign [`FM_NUM_SLICES];
	logic                        b_slice_sign [`FM_NUM_SLICES];
	fused_mult_pkg::slice_prod_t product      [`FM_NUM_SLICES];

	operand_distributor u_operand_distributor (
		.a            (a),
		.b            (b),
		.a_sign       (a_sign),
		.b_sign       (b_sign),
		.mode         (mode),
		.a_slice      (a_slice),
		.b_slice      (b_slice),
		.a_slice_sign (a_slice_sign),
		.b_slice_sign (b_slice_sign)
	);

	for (genvar k = 0; k < `FM_NUM_SLICES; k++) begin : g_slice
		slice_mult u_slice_mult (
			.clk     (clk),
			.reset   (reset),
			.a_slice (a_slice[k]),
			.b_slice (b_slice[k]),
			.a_sign  (a_slice_sign[k]),
			.b_sign  (b_slice_sign[k]),
			.mode    (mode),
			.product (product[k])
		);
	end

	// controls taken from the top, delayed inside the reducer
	product_reducer u_product_reducer (
		.clk     (clk),
		.reset   (reset),
		.product (product),
		.mode    (mode),
		.a_sign  (a_sign),
		.b_sign  (b_sign),
		.result  (result)
	);

endmodule

`default_nettype wire

// File: bench/fused_mult_checker.sv
`default_nettype none

`include "fused_mult_config.svh"

module fused_mult_checker (
	input logic                    clk,
	input logic                    reset,
	input fused_mult_pkg::mode_t   mode,
	input fused_mult_pkg::mode_t   mode_q,
	input fused_mult_pkg::result_t result
);
	timeunit 1ns;
	timeprecision 100ps;

	// 24 two-bit lane products over every sign choice
	localparam longint SUM2_MIN = -144;
	localparam longint SUM2_MAX = 216;

	int fail_count = 0;

	result_zero_after_reset: assert property (@(posedge clk) $fell(reset) |-> result == '0)
		else begin
			$error("result not zero in the first cycle after reset");
			fail_count++;
		end

	mode_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mode))
		else begin
			$error("mode carries X or Z");
			fail_count++;
		end

	// the sum registered one cycle after the delayed mode
	sum2_in_range: assert property (@(posedge clk) disable iff (reset)
		(mode_q == `FM_MODE_SUM2) |=> ($signed(result) >= SUM2_MIN && $signed(result) <= SUM2_MAX))
		else begin
			$error("sum of 2x2 products out of range");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: bench/fused_mult_tb.sv
`default_nettype none

`include "fused_mult_config.svh"

module fused_mult_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_COUNT = 200;
	localparam int WIDE_A_W     = 27;
	localparam int WIDE_B_W     = 18;

	logic                     clk;
	logic                     reset;
	fused_mult_pkg::operand_t a;
	fused_mult_pkg::operand_t b;
	logic                     a_sign;
	logic                     b_sign;
	fused_mult_pkg::mode_t    mode;
	fused_mult_pkg::result_t  result;

	fused_mult_top u_fused_mult_top (
		.clk    (clk),
		.reset  (reset),
		.a      (a),
		.b      (b),
		.a_sign (a_sign),
		.b_sign (b_sign),
		.mode   (mode),
		.result (result)
	);

	bind product_reducer fused_mult_checker u_fused_mult_checker (
		.clk    (clk),
		.reset  (reset),
		.mode   (mode),
		.mode_q (mode_q),
		.result (result)
	);

	// vectors from the data file
	fused_mult_pkg::mode_t    file_mode     [$];
	logic                     file_a_sign   [$];
	logic                     file_b_sign   [$];
	fused_mult_pkg::operand_t file_a        [$];
	fused_mult_pkg::operand_t file_b        [$];
	fused_mult_pkg::result_t  file_expected [$];

	// one entry per operation still in the pipeline
	fused_mult_pkg::result_t  expected_q [$];

	logic [31:0] lfsr_state;
	int          check_count;
	int          error_count;
	int          cycle_count = 0;
	int          cycle_limit;
	logic        limit_ready = 1'b0;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin : watchdog
		wait (limit_ready);
		while (cycle_count < cycle_limit) @(posedge clk);
		$display("timeout: run still going after %0d cycles", cycle_limit);
		$display("Checks failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value[i] = lfsr_state[0];
		end
		return value;
	endfunction

	function automatic longint lane_value(input fused_mult_pkg::operand_t v, input int lsb,
		input int width, input logic is_signed);
		longint field;
		field = 0;
		for (int i = 0; i < width; i++) begin
			field[i] = v[lsb + i];
		end
		if (is_signed && field[width-1]) begin
			field = field - (longint'(1) << width);
		end
		return field;
	endfunction

	// reference: wide product or sum of lane products
	function automatic fused_mult_pkg::result_t model_result(input fused_mult_pkg::mode_t m,
		input logic as, input logic bs, input fused_mult_pkg::operand_t va,
		input fused_mult_pkg::operand_t vb);
		longint total;
		int     width;
		int     lanes;
		total = 0;
		if (m == `FM_MODE_27X18) begin
			total = lane_value(va, 0, WIDE_A_W, as) * lane_value(vb, 0, WIDE_B_W, bs);
		end else begin
			case (m)
				`FM_MODE_SUM9: begin
					width = 9;
					lanes = 1;
				end
				`FM_MODE_SUM4: begin
					width = 4;
					lanes = 2;
				end
				default: begin
					width = 2;
					lanes = 4;
				end
			endcase
			for (int k = 0; k < `FM_NUM_SLICES; k++) begin
				for (int l = 0; l < lanes; l++) begin
					total = total + lane_value(va, 9*k + width*l, width, as)
						* lane_value(vb, 9*k + width*l, width, bs);
				end
			end
		end
		return total[`FM_RESULT_W-1:0];
	endfunction

	task automatic check_result(input fused_mult_pkg::result_t actual,
		input fused_mult_pkg::result_t expected, input string name);
		check_count++;
		if (actual !== expected) begin
			$display("[ERROR] %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_next;
		fused_mult_pkg::result_t expected;
		expected = expected_q.pop_front();
		check_result(result, expected, "result");
	endtask

	// drive on the falling edge, result two cycles on
	task automatic run_op(input fused_mult_pkg::mode_t m, input logic as, input logic bs,
		input fused_mult_pkg::operand_t va, input fused_mult_pkg::operand_t vb,
		input fused_mult_pkg::result_t expected);
		@(negedge clk);
		if (expected_q.size() == 2) begin
			check_next();
		end
		mode   = m;
		a_sign = as;
		b_sign = bs;
		a      = va;
		b      = vb;
		expected_q.push_back(expected);
	endtask

	task automatic drain_pipeline;
		while (expected_q.size() > 0) begin
			@(negedge clk);
			check_next();
		end
	endtask

	task automatic report_test(input string name, input int checks_before, input int errors_before);
		$display("test %s: %0d checks, %0d errors", name, check_count - checks_before,
			error_count - errors_before);
	endtask

	task automatic load_vectors;
		int                       fd;
		int                       n;
		string                    line;
		fused_mult_pkg::mode_t    v_mode;
		logic                     v_as;
		logic                     v_bs;
		fused_mult_pkg::operand_t v_a;
		fused_mult_pkg::operand_t v_b;
		fused_mult_pkg::result_t  v_exp;
		fd = $fopen("bench/fused_mult_input.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/fused_mult_input.txt");
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() > 1 && line.substr(0, 1) != "//") begin
					n = $sscanf(line, "%h %h %h %h %h %h", v_mode, v_as, v_bs, v_a, v_b, v_exp);
					if (n == 6) begin
						file_mode.push_back(v_mode);
						file_a_sign.push_back(v_as);
						file_b_sign.push_back(v_bs);
						file_a.push_back(v_a);
						file_b.push_back(v_b);
						file_expected.push_back(v_exp);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// an operation already sits on the inputs while reset is held
	task automatic test_reset;
		int checks_before;
		int errors_before;
		checks_before = check_count;
		errors_before = error_count;
		check_result(result, '0, "result");
		@(negedge clk);
		check_result(result, '0, "result");
		@(negedge clk);
		check_result(result, model_result(mode, a_sign, b_sign, a, b), "result");
		report_test("reset", checks_before, errors_before);
	endtask

	task automatic test_file;
		int checks_before;
		int errors_before;
		checks_before = check_count;
		errors_before = error_count;
		if (file_mode.size() == 0) begin
			$display("no vectors were read from the data file");
			error_count++;
		end
		for (int i = 0; i < file_mode.size(); i++) begin
			run_op(file_mode[i], file_a_sign[i], file_b_sign[i], file_a[i], file_b[i],
				file_expected[i]);
		end
		drain_pipeline();
		report_test("file vectors", checks_before, errors_before);
	endtask

	task automatic test_random;
		int                       checks_before;
		int                       errors_before;
		fused_mult_pkg::mode_t    v_mode;
		fused_mult_pkg::mode_t    mode_flip;
		logic [1:0]               sign_flip;
		logic                     v_as;
		logic                     v_bs;
		fused_mult_pkg::operand_t v_a;
		fused_mult_pkg::operand_t v_b;
		checks_before = check_count;
		errors_before = error_count;
		v_mode = mode;
		v_as   = a_sign;
		v_bs   = b_sign;
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			// mode and signs both change on every operation
			do begin
				mode_flip = fused_mult_pkg::mode_t'(random_bits(2));
			end while (mode_flip == '0);
			do begin
				sign_flip = 2'(random_bits(2));
			end while (sign_flip == '0);
			v_mode = v_mode ^ mode_flip;
			v_as   = v_as ^ sign_flip[1];
			v_bs   = v_bs ^ sign_flip[0];
			v_a    = fused_mult_pkg::operand_t'(random_bits(`FM_OPERAND_W));
			v_b    = fused_mult_pkg::operand_t'(random_bits(`FM_OPERAND_W));
			run_op(v_mode, v_as, v_bs, v_a, v_b, model_result(v_mode, v_as, v_bs, v_a, v_b));
		end
		drain_pipeline();
		report_test("random vectors", checks_before, errors_before);
	endtask

	initial begin : main
		int assert_fails;
		reset       = 1'b1;
		mode        = `FM_MODE_27X18;
		a_sign      = 1'b0;
		b_sign      = 1'b0;
		a           = '1;
		b           = '1;
		check_count = 0;
		error_count = 0;
		lfsr_state  = 32'h6050;
		load_vectors();
		cycle_limit = (file_mode.size() + RANDOM_COUNT + RESET_CYCLES + 10) * 2;
		limit_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_file();
		test_random();
		assert_fails = u_fused_mult_top.u_product_reducer.u_fused_mult_checker.fail_count;
		error_count = error_count + assert_fails;
		$display("total: %0d checks, %0d errors, %0d assertion failures", check_count,
			error_count, assert_fails);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/fused_mult_input.txt
// mode a_sign b_sign a b expected, all hex
// mode 0 is 27x18, 1 sum of 9x9, 2 sum of 4x4, 3 sum of 2x2
0 0 0 3 5 f
0 0 0 7ffffff 3ffff 1ffff7fc0001
0 1 1 4000000 20000 80000000000
0 1 0 7ffffff 5 1ffffffffffb
0 0 1 3 3ffff 1ffffffffffd
0 1 1 7ffffff 3ffff 1
0 1 0 4000000 3ffff 100004000000
0 0 1 7ffffff 20000 100000020000
0 1 1 3ffffff8000002 fffc0007 e
0 1 1 7fffffd 10 1fffffffffd0
0 0 0 123 10 1230
0 1 1 4000000 1 1ffffc000000
1 0 0 201008040201 201008040201 6
1 0 0 3fffffffffffff 3fffffffffffff 17e806
1 1 1 3fffffffffffff 3fffffffffffff 6
1 1 1 3fffffffffffff 201008040201 1ffffffffffa
1 1 0 3fffffffffffff 3fffffffffffff 1ffffffff406
1 1 1 20100804020100 20100804020100 60000
1 1 0 20100804020100 3fffffffffffff 1ffffff40600
1 0 0 1fe 3 5fa
1 1 1 1fe 3 1ffffffffffa
1 0 0 0 3fffffffffffff 0
1 1 1 201008040201 20100804020100 1ffffffffa00
2 0 0 3fffffffffffff 3fffffffffffff a8c
2 1 1 3fffffffffffff 3fffffffffffff c
2 1 1 11088442211088 11088442211088 300
2 1 0 3fffffffffffff 3fffffffffffff 1fffffffff4c
2 0 0 20100804020100 3fffffffffffff 0
2 1 1 3fffffffffffff 2211088442211 1ffffffffff4
2 0 0 201008040201 3fffffffffffff 5a
3 0 0 3fffffffffffff 3fffffffffffff d8
3 1 1 3fffffffffffff 3fffffffffffff 18
3 1 1 154aa552a954aa 154aa552a954aa 60
3 1 0 3fffffffffffff 3fffffffffffff 1fffffffffb8
3 1 1 154aa552a954aa aa552a954aa55 1fffffffffd0
3 0 0 201008040201 201008040201 6
3 0 0 20100804020100 3fffffffffffff 0

// File: fused_mult_top.f
+incdir+common
common/fused_mult_pkg.sv
src/operand_distributor.sv
slice_mult/slice_mult.sv
src/product_reducer.sv
src/fused_mult_top.sv
bench/fused_mult_checker.sv
bench/fused_mult_tb.sv

// File: Bender.yml
package:
  name: fused_mult

sources:
  - include_dirs:
      - common
    files:
      - common/fused_mult_pkg.sv
      - src/operand_distributor.sv
      - slice_mult/slice_mult.sv
      - src/product_reducer.sv
      - src/fused_mult_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - bench/fused_mult_checker.sv
      - bench/fused_mult_tb.sv
